/* vm_gate_defs.svh */
`ifndef VM_GATE_DEFS_SVH
`define VM_GATE_DEFS_SVH

// datapath shape
`define VM_LANES 8
`define VM_WORD 16
`define VM_FRAC 12      // Q4.12

// memory depths
`define VM_ROWS 16      // weight rows
`define VM_VECS 4       // input vectors

// results the consumer can hold before returning credits
`define VM_CREDITS 4

`endif

/* vm_gate_pkg.sv */
`include "vm_gate_defs.svh"

package vm_gate_pkg;

	typedef logic [`VM_WORD-1:0] word_t;                  // Q4.12, two's complement
	typedef logic [`VM_LANES*`VM_WORD-1:0] row_t;         // lane 0 in the low word
	typedef logic [$clog2(`VM_ROWS)-1:0] row_addr_t;
	typedef logic [$clog2(`VM_VECS)-1:0] vec_addr_t;
	typedef logic [$clog2(`VM_CREDITS+1)-1:0] credit_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN   // all rows issued, waiting for the last result
	} seq_state_t;

endpackage

/* vm_row_if.sv */
`timescale 1ns/1ns

// one row of operands (or products) moving between pipeline stages
interface vm_row_if;
	import vm_gate_pkg::*;

	logic valid;
	row_t operand_a;   // vector before the multipliers, products after
	row_t operand_b;   // weights
	logic last;        // final row of the final vector

	modport src (
		output valid,
		output operand_a,
		output operand_b,
		output last
	);

	modport dst (
		input valid,
		input operand_a,
		input operand_b,
		input last
	);

endinterface

/* vm_operand_ram.sv */
`timescale 1ns/1ns
`include "vm_gate_defs.svh"

module vm_operand_ram (
	input logic clk,
	input logic load_we,
	input logic load_is_vec,
	input vm_gate_pkg::row_addr_t load_addr,
	input vm_gate_pkg::row_t load_data,
	input logic issue,
	input logic issue_last,
	input vm_gate_pkg::row_addr_t row_addr,
	input vm_gate_pkg::vec_addr_t vec_addr,
	vm_row_if.src out_row
);
	import vm_gate_pkg::*;

	row_t weight_mem [`VM_ROWS];
	row_t vec_mem [`VM_VECS];
	vec_addr_t load_vec_addr;

	assign load_vec_addr = vec_addr_t'(load_addr);   // vector memory is shallower

	// loading only happens while the engine is idle
	always_ff @(posedge clk) begin
		if (load_we) begin
			if (load_is_vec)
				vec_mem[load_vec_addr] <= load_data;
			else
				weight_mem[load_addr] <= load_data;
		end
	end

	// registered read, tagged with the issue that asked for it
	always_ff @(posedge clk) begin
		out_row.operand_a <= vec_mem[vec_addr];
		out_row.operand_b <= weight_mem[row_addr];
		out_row.valid <= issue;   // sequencer holds issue low in reset
		out_row.last <= issue_last;
	end

	a_no_load_during_issue: assert property (
		@(posedge clk) !(load_we && issue)
	) else $error("weight/vector memory written while a row is issued");

endmodule

/* vm_sequencer.sv */
`timescale 1ns/1ns
`include "vm_gate_defs.svh"

module vm_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input vm_gate_pkg::row_addr_t end_row,
	input vm_gate_pkg::vec_addr_t end_vec,
	input logic credit_return,
	input logic result_last,
	output logic issue,
	output logic issue_last,
	output vm_gate_pkg::row_addr_t row_addr,
	output vm_gate_pkg::vec_addr_t vec_addr,
	output logic busy,
	output logic done
);
	import vm_gate_pkg::*;

	seq_state_t state;
	credit_t credits;
	logic row_wrap;
	logic done_q;

	assign row_wrap = (row_addr == end_row);
	assign issue = (state == RUN) && (credits != '0);   // one credit per row
	assign issue_last = issue && row_wrap && (vec_addr == end_vec);
	assign busy = (state != IDLE);

	// done rises with the final ht_valid, then holds until the next start
	assign done = done_q || ((state == DRAIN) && result_last);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
			row_addr <= '0;
			vec_addr <= '0;
			done_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						row_addr <= '0;
						vec_addr <= '0;
						done_q <= 1'b0;
						state <= RUN;
					end
				end
				RUN: begin
					if (issue) begin
						if (row_wrap) begin
							row_addr <= '0;
							vec_addr <= vec_addr + 1'b1;
						end else begin
							row_addr <= row_addr + 1'b1;
						end
						if (issue_last)
							state <= DRAIN;
					end
				end
				DRAIN: begin
					if (result_last) begin   // last row has left the adder tree
						done_q <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// credit counter
	always_ff @(posedge clk) begin
		if (!reset)
			credits <= credit_t'(`VM_CREDITS);
		else if (issue && !credit_return)
			credits <= credits - 1'b1;
		else if (!issue && credit_return)
			credits <= credits + 1'b1;
	end

	// the consumer must never hand back more credits than it was given
	a_credit_limit: assert property (
		@(posedge clk) disable iff (!reset) credits <= credit_t'(`VM_CREDITS)
	) else $error("credit count above limit");

endmodule

/* vm_product_stage.sv */
`timescale 1ns/1ns
`include "vm_gate_defs.svh"

module vm_product_stage (
	input logic clk,
	input logic reset,
	vm_row_if.dst in_row,
	vm_row_if.src out_row
);
	import vm_gate_pkg::*;

	logic valid_1, last_1;
	logic valid_2, last_2;
	row_t prod_row;

	genvar i;
	generate
		for (i = 0; i < `VM_LANES; i = i + 1) begin : g_lane
			word_t a_in, b_in;
			word_t mag_a, mag_b;
			logic sign_a, sign_b;
			logic sign_diff;
			logic [2*`VM_WORD-1:0] product;
			logic [`VM_WORD-2:0] kept;

			assign a_in = in_row.operand_a[i*`VM_WORD +: `VM_WORD];
			assign b_in = in_row.operand_b[i*`VM_WORD +: `VM_WORD];

			always_ff @(posedge clk) begin
				mag_a <= a_in[`VM_WORD-1] ? (~a_in + 1'b1) : a_in;
				mag_b <= b_in[`VM_WORD-1] ? (~b_in + 1'b1) : b_in;
				sign_a <= a_in[`VM_WORD-1];
				sign_b <= b_in[`VM_WORD-1];
				product <= mag_a * mag_b;   // full 32-bit unsigned product
				sign_diff <= sign_a ^ sign_b;
			end

			assign kept = product[`VM_FRAC+`VM_WORD-2:`VM_FRAC];   // bits 26..12
			// sign restored after the magnitude multiply
			assign prod_row[i*`VM_WORD +: `VM_WORD] =
				sign_diff ? (~{1'b0, kept} + 1'b1) : {1'b0, kept};
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_1 <= 1'b0;
			last_1 <= 1'b0;
			valid_2 <= 1'b0;
			last_2 <= 1'b0;
		end else begin
			valid_1 <= in_row.valid;
			last_1 <= in_row.last;
			valid_2 <= valid_1;
			last_2 <= last_1;
		end
	end

	assign out_row.valid = valid_2;
	assign out_row.last = last_2;
	assign out_row.operand_a = prod_row;
	assign out_row.operand_b = '0;   // no second operand past the multipliers

endmodule

/* vm_adder_tree.sv */
`timescale 1ns/1ns
`include "vm_gate_defs.svh"

module vm_adder_tree (
	input logic clk,
	input logic reset,
	vm_row_if.dst in_row,
	output vm_gate_pkg::word_t ht_out,
	output logic ht_valid,
	output logic result_last
);
	import vm_gate_pkg::*;

	word_t sum1 [`VM_LANES/2];
	word_t sum2 [`VM_LANES/4];
	word_t sum2_q [`VM_LANES/4];
	logic valid_q, last_q;

	// levels one and two, wrapping 16-bit adds
	always_comb begin
		for (int j = 0; j < `VM_LANES/2; j++) begin
			sum1[j] = in_row.operand_a[(2*j)*`VM_WORD +: `VM_WORD]
				+ in_row.operand_a[(2*j+1)*`VM_WORD +: `VM_WORD];
		end
		for (int k = 0; k < `VM_LANES/4; k++) begin
			sum2[k] = sum1[2*k] + sum1[2*k+1];
		end
	end

	always_ff @(posedge clk) begin
		sum2_q <= sum2;   // mid-tree register
		ht_out <= sum2_q[0] + sum2_q[1];
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_q <= 1'b0;
			last_q <= 1'b0;
			ht_valid <= 1'b0;
			result_last <= 1'b0;
		end else begin
			valid_q <= in_row.valid;
			last_q <= in_row.valid && in_row.last;
			ht_valid <= valid_q;
			result_last <= last_q;
		end
	end

endmodule

/* vm_gate_top.sv */
`timescale 1ns/1ns

module vm_gate_top (
	input logic clk,
	input logic reset,
	input logic load_we,
	input logic load_is_vec,
	input vm_gate_pkg::row_addr_t load_addr,
	input vm_gate_pkg::row_t load_data,
	input logic start,
	input vm_gate_pkg::row_addr_t end_row,
	input vm_gate_pkg::vec_addr_t end_vec,
	input logic credit_return,
	output vm_gate_pkg::word_t ht_out,
	output logic ht_valid,
	output logic busy,
	output logic done
);
	import vm_gate_pkg::*;

	logic issue;
	logic issue_last;
	logic result_last;
	row_addr_t row_addr;
	vec_addr_t vec_addr;

	vm_row_if mem_row ();    // operands, ram -> multipliers
	vm_row_if prod_row ();   // products, multipliers -> adder tree

	vm_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.end_row(end_row),
		.end_vec(end_vec),
		.credit_return(credit_return),
		.result_last(result_last),
		.issue(issue),
		.issue_last(issue_last),
		.row_addr(row_addr),
		.vec_addr(vec_addr),
		.busy(busy),
		.done(done)
	);

	vm_operand_ram u_operand_ram (
		.clk(clk),
		.load_we(load_we),
		.load_is_vec(load_is_vec),
		.load_addr(load_addr),
		.load_data(load_data),
		.issue(issue),
		.issue_last(issue_last),
		.row_addr(row_addr),
		.vec_addr(vec_addr),
		.out_row(mem_row.src)
	);

	vm_product_stage u_product_stage (
		.clk(clk),
		.reset(reset),
		.in_row(mem_row.dst),
		.out_row(prod_row.src)
	);

	vm_adder_tree u_adder_tree (
		.clk(clk),
		.reset(reset),
		.in_row(prod_row.dst),
		.ht_out(ht_out),
		.ht_valid(ht_valid),
		.result_last(result_last)
	);

endmodule

/* tb_vm_gate.sv */
`timescale 1ns/1ns
`include "vm_gate_defs.svh"

module tb_vm_gate;
	import vm_gate_pkg::*;

	logic clk;
	logic reset;
	logic load_we;
	logic load_is_vec;
	row_addr_t load_addr;
	row_t load_data;
	logic start;
	row_addr_t end_row;
	vec_addr_t end_vec;
	logic credit_return;
	word_t ht_out;
	logic ht_valid;
	logic busy;
	logic done;

	logic [135:0] stim [0:63];
	int seed;
	int owed;            // results taken whose credit has not gone back yet
	int returned;
	logic hold_credits;
	int errors;
	int tests_failed;
	int watch_cycles;

	vm_gate_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one clock, then the consumer decides whether to hand a credit back
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (ht_valid)
			owed++;
		if (!hold_credits && owed > 0 && ($random(seed) & 1) != 0) begin
			credit_return = 1'b1;
			owed--;
			returned++;
		end else begin
			credit_return = 1'b0;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_result(input word_t want);
		if (ht_out !== want) begin
			$display("error at %0t ns: ht_out = %h, expected %h", $time, ht_out, want);
			errors++;
		end
	endtask

	task automatic load_entry(input logic [135:0] entry);
		load_we = 1'b1;
		load_is_vec = entry[132];
		load_addr = entry[131:128];
		load_data = entry[127:0];
		next_cycle();
	endtask

	function automatic string test_name(input int num);
		case (num)
			1: return "dot products";
			2: return "sign handling";
			3: return "vector sweep";
			4: return "credit limit";
			5: return "done and busy";
			6: return "reload";
			default: return "extra run";
		endcase
	endfunction

	task automatic run_test(input int num, input logic [135:0] hdr, input logic [135:0] want_all);
		int nres;
		int got;
		int quiet;
		int errs_before;
		int returned_base;
		int granted;
		logic finished;
		nres = int'(hdr[7:0]);
		got = 0;
		quiet = 0;
		finished = 1'b0;
		errs_before = errors;
		while (owed > 0)
			next_cycle();   // all credits home before the next run
		if (busy)
			note_failure("busy is high before start");
		if (num > 1 && !done)
			note_failure("done fell before the next start");
		hold_credits = hdr[32];
		end_row = hdr[19:16];
		end_vec = hdr[9:8];
		returned_base = returned;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		granted = `VM_CREDITS;
		while (!finished) begin
			if (!busy)
				note_failure("busy dropped while the run was in progress");
			if (ht_valid) begin
				if (hold_credits && got >= `VM_CREDITS)
					note_failure("a result appeared while credits were held back");
				if (got + 1 > granted)
					note_failure("more results than credits granted");
				if (got < nres)
					check_result(want_all[16*got +: 16]);
				else
					note_failure("more results than expected");
				got++;
			end else if (hold_credits && got >= `VM_CREDITS) begin
				quiet++;
				if (quiet == 20)
					hold_credits = 1'b0;   // stall has lasted long enough to release credits
			end
			if (done) begin
				if (!ht_valid || got != nres)
					note_failure("done did not rise with the last result");
				finished = 1'b1;
			end else begin
				granted = `VM_CREDITS + returned - returned_base;
				next_cycle();
			end
		end
		next_cycle();
		if (busy || !done || ht_valid)
			note_failure("busy, done or ht_valid wrong in the cycle after done");
		if (errors == errs_before) begin
			$display("test %0d %s: passed, %0d results", num, test_name(num), got);
		end else begin
			$display("test %0d %s: failed", num, test_name(num));
			tests_failed++;
		end
	endtask

	initial begin
		int num_tests;
		int total;
		int ptr;
		int idx;
		int nloads;
		logic [135:0] hdr;
		seed = 79303;
		load_we = 1'b0;
		load_is_vec = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		end_row = '0;
		end_vec = '0;
		credit_return = 1'b0;
		hold_credits = 1'b0;
		reset = 1'b0;
		$readmemh("vm_gate_stimulus.txt", stim);
		num_tests = int'(stim[0][7:0]);
		total = 0;
		ptr = 1;
		for (idx = 0; idx < num_tests; idx++) begin
			total += int'(stim[ptr][7:0]);
			ptr += int'(stim[ptr][31:24]) + 2;   // header, loads, expected line
		end
		watch_cycles = total * 20 + 200;
		repeat (3) next_cycle();
		reset = 1'b1;
		if (num_tests == 0)
			note_failure("the stimulus file holds no tests");
		ptr = 1;
		for (idx = 1; idx <= num_tests; idx++) begin
			hdr = stim[ptr];
			nloads = int'(hdr[31:24]);
			ptr++;
			repeat (nloads) begin
				load_entry(stim[ptr]);
				ptr++;
			end
			load_we = 1'b0;
			run_test(idx, hdr, stim[ptr]);
			ptr++;
		end
		$display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", watch_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* vm_gate_stimulus.txt */
// first line: number of tests. each test: header {hold, loads, end_row, end_vec, results},
// then loads {is_vec, addr, row with lane 0 rightmost}, then expected results, first rightmost
6
0005030004 // dot products
0001000100010001000100010001000100
0102000200020002000200020002000200
02000000000000000000000800F0001000
0307000600050004000300020001000000
1010001000100010001000100010001000
1C00080010000800
0001020003 // sign handling, vector 0 gets mixed signs
1004000400040004001000F8000800F000
E40002000100
0003010206 // vector sweep
1010001000100010001000100010001000
1108000800080008000800080008000800
1204000400040004001000F8000800F000
020001000800040010000800
0104070008 // credit limit, credits held back
0403000300030003000300030003000300
0504000400040004000400040004000400
06FF00FF00FF00FF00FF00FF00FF00FF00
0710001000100010001000100010001000
8000F800200018001C00080010000800
0000000102 // done and busy, one row per vector
04000800
0001010002 // reload row 1 with -0.5 in every lane
01F800F800F800F800F800F800F800F800
C0000800

/* vm_gate.f */
+incdir+.
vm_gate_pkg.sv
vm_row_if.sv
vm_operand_ram.sv
vm_sequencer.sv
vm_product_stage.sv
vm_adder_tree.sv
vm_gate_top.sv
tb_vm_gate.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_vm_gate -f vm_gate.f -o vm_gate_sim
./obj_dir/vm_gate_sim | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
